//--- all.f
+incdir+bench
design/arcade_pkg.sv
design/ps2_receiver.sv
design/key_decoder.sv
design/control_mapper.sv
design/sigma_delta_dac.sv
design/video_output.sv
design/arcade_io_top.sv
bench/tb_arcade_io.sv

//--- run_sim.sh
#!/bin/sh
# build the arcade I/O testbench with Verilator and run it into sim.log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f all.f --top-module tb_arcade_io -o sim_tb_arcade_io
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_arcade_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	echo "testbench reported failure, see $LOG"
	exit 1
fi

echo "testbench run complete, see $LOG"
exit 0

//--- bench/tb_arcade_io_tasks.svh
`ifndef TB_ARCADE_IO_TASKS_SVH
`define TB_ARCADE_IO_TASKS_SVH

// ####################
// reference models
// ####################
// the eight controls are packed at the keyboard word positions
function automatic control_word_t expected_controls(input control_word_t kb,
		input control_word_t j0, input control_word_t j1, input logic rot);
	logic          held_up;
	logic          held_down;
	logic          held_left;
	logic          held_right;
	control_word_t res;
	held_up       = kb[KB_UP] | j0[JOY_UP] | j1[JOY_UP];
	held_down     = kb[KB_DOWN] | j0[JOY_DOWN] | j1[JOY_DOWN];
	held_left     = kb[KB_LEFT] | j0[JOY_LEFT] | j1[JOY_LEFT];
	held_right    = kb[KB_RIGHT] | j0[JOY_RIGHT] | j1[JOY_RIGHT];
	res           = kb;
	res[KB_FIRE]  = kb[KB_FIRE] | j0[JOY_FIRE] | j1[JOY_FIRE];
	// a quarter turn when the cabinet is not rotated
	res[KB_UP]    = rot ? held_up : held_left;
	res[KB_DOWN]  = rot ? held_down : held_right;
	res[KB_LEFT]  = rot ? held_left : held_down;
	res[KB_RIGHT] = rot ? held_right : held_up;
	return res;
endfunction

function automatic vga_level_t expected_vga(input game_color_t level, input logic blank);
	if (blank) begin
		return '0;
	end
	return {level, level};
endfunction

// ####################
// PS/2 keyboard model
// ####################
// start, data LSB first, odd parity, stop; data moves while the clock is high
task automatic send_frame(input scan_code_t data, input logic bad_parity);
	logic [10:0] frame;
	frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
	for (int i = 0; i < 11; i++) begin
		@(posedge clock_48);
		ps2_kbd_data <= frame[i];
		repeat (PS2_HALF) @(posedge clock_48);
		ps2_kbd_clk <= 1'b0;
		repeat (PS2_HALF) @(posedge clock_48);
		ps2_kbd_clk <= 1'b1;
	end
	@(posedge clock_48);
	ps2_kbd_data <= 1'b1;
	repeat (PS2_HALF) @(posedge clock_48);
endtask

// ####################
// compare tasks
// ####################
task automatic compare_controls(input control_word_t got, input control_word_t want);
	if (got !== want) begin
		mismatch_errors++;
		$display("Mismatch controls: got %h expected %h at %0t", got, want, $time);
	end
endtask

task automatic compare_vga(input string name, input vga_level_t got, input vga_level_t want);
	if (got !== want) begin
		mismatch_errors++;
		$display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
	end
endtask

task automatic compare_bit(input string name, input logic got, input logic want);
	if (got !== want) begin
		mismatch_errors++;
		$display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
	end
endtask

task automatic compare_density(input audio_sample_t sample, input int ones);
	int diff;
	diff = ones - int'(sample);
	if (diff > 1 || diff < -1) begin
		mismatch_errors++;
		$display("Mismatch audio_out ones count: got %h expected %h within one", ones, sample);
	end
endtask

`endif

//--- bench/tb_arcade_io.sv
`timescale 1ns/100ps

module tb_arcade_io;
	import arcade_pkg::*;

	localparam int PS2_HALF     = 60;
	localparam int SETTLE_LIMIT = 64;
	localparam int VIDEO_CYCLES = 200;

	logic          clock_48;
	logic          arst_n;
	logic          ps2_kbd_clk;
	logic          ps2_kbd_data;
	control_word_t joystick_0;
	control_word_t joystick_1;
	logic          rotate;
	audio_sample_t audio_in;
	game_color_t   video_r;
	game_color_t   video_g;
	logic [1:0]    video_b;
	logic          hblank;
	logic          vblank;
	logic          hs;
	logic          vs;
	logic          up;
	logic          down;
	logic          left;
	logic          right;
	logic          fire;
	logic          start1;
	logic          start2;
	logic          coin;
	logic          audio_out;
	vga_level_t    vga_r;
	vga_level_t    vga_g;
	vga_level_t    vga_b;
	logic          vga_hs;
	logic          vga_vs;
	logic          frame_error;

	control_word_t actual_controls;
	control_word_t kb_model;
	integer        seed;
	logic [31:0]   rnd;
	int            mismatch_errors;
	int            timeout_errors;
	int            frame_error_pulses = 0;
	vga_level_t    exp_r;
	vga_level_t    exp_g;
	vga_level_t    exp_b;
	logic          exp_hs;
	logic          exp_vs;

	`include "tb_arcade_io_tasks.svh"

	arcade_io_top UUT (.*);

	// same bit order as the keyboard word
	assign actual_controls = {right, left, down, up, coin, start2, start1, fire};

	initial begin
		clock_48 = 1'b0;
		forever #10 clock_48 = ~clock_48;
	end

	always @(negedge clock_48) begin
		if (frame_error === 1'b1) begin
			frame_error_pulses++;
		end
	end

	task automatic check_controls_settled();
		int            waited;
		control_word_t want;
		waited = 0;
		want   = expected_controls(kb_model, joystick_0, joystick_1, rotate);
		@(negedge clock_48);
		while (actual_controls !== want && waited < SETTLE_LIMIT) begin
			@(negedge clock_48);
			waited++;
		end
		if (actual_controls !== want) begin
			timeout_errors++;
			$display("controls did not settle within %0d cycles after a PS/2 frame", SETTLE_LIMIT);
		end
		compare_controls(actual_controls, want);
	endtask

	// an arrow release arrives as E0 F0 code
	task automatic key_event(input scan_code_t sc, input int bit_idx, input logic extended,
			input logic is_release);
		if (extended) begin
			send_frame(SC_EXTENDED, 1'b0);
			check_controls_settled();
		end
		if (is_release) begin
			send_frame(SC_BREAK, 1'b0);
			check_controls_settled();
		end
		send_frame(sc, 1'b0);
		kb_model[bit_idx] = ~is_release;
		check_controls_settled();
	endtask

	task automatic capture_video_expectation();
		exp_r  = expected_vga(video_r, hblank | vblank);
		exp_g  = expected_vga(video_g, hblank | vblank);
		exp_b  = expected_vga(game_color_t'({video_b, video_b[0]}), hblank | vblank);
		exp_hs = hs;
		exp_vs = vs;
	endtask

	initial begin
		int            pulses_before;
		int            waited;
		int            ones;
		audio_sample_t sample;
		seed            = 45;
		mismatch_errors = 0;
		timeout_errors  = 0;
		kb_model        = '0;
		arst_n          = 1'b0;
		ps2_kbd_clk     = 1'b1;
		ps2_kbd_data    = 1'b1;
		joystick_0      = '0;
		joystick_1      = '0;
		rotate          = 1'b1;
		audio_in        = '0;
		video_r         = '0;
		video_g         = '0;
		video_b         = '0;
		hblank          = 1'b0;
		vblank          = 1'b0;
		hs              = 1'b0;
		vs              = 1'b0;

		repeat (5) @(posedge clock_48);
		@(negedge clock_48);
		compare_controls(actual_controls, '0);
		compare_bit("audio_out", audio_out, 1'b0);
		compare_vga("vga_r", vga_r, '0);
		compare_vga("vga_g", vga_g, '0);
		compare_vga("vga_b", vga_b, '0);
		compare_bit("vga_hs", vga_hs, 1'b0);
		compare_bit("vga_vs", vga_vs, 1'b0);
		compare_bit("frame_error", frame_error, 1'b0);
		repeat (5) @(posedge clock_48);
		arst_n <= 1'b1;

		// ####################
		// keyboard press and release
		// ####################
		key_event(SC_SPACE, KB_FIRE, 1'b0, 1'b0);
		key_event(SC_F1, KB_START1, 1'b0, 1'b0);
		key_event(SC_F2, KB_START2, 1'b0, 1'b0);
		key_event(SC_F3, KB_COIN, 1'b0, 1'b0);
		key_event(SC_UP, KB_UP, 1'b1, 1'b0);
		key_event(SC_DOWN, KB_DOWN, 1'b1, 1'b0);
		key_event(SC_LEFT, KB_LEFT, 1'b1, 1'b0);
		key_event(SC_RIGHT, KB_RIGHT, 1'b1, 1'b0);
		key_event(SC_SPACE, KB_FIRE, 1'b0, 1'b1);
		key_event(SC_F1, KB_START1, 1'b0, 1'b1);
		key_event(SC_F2, KB_START2, 1'b0, 1'b1);
		key_event(SC_F3, KB_COIN, 1'b0, 1'b1);
		key_event(SC_UP, KB_UP, 1'b1, 1'b1);
		key_event(SC_DOWN, KB_DOWN, 1'b1, 1'b1);
		key_event(SC_LEFT, KB_LEFT, 1'b1, 1'b1);
		key_event(SC_RIGHT, KB_RIGHT, 1'b1, 1'b1);

		// an arrow code without the E0 prefix is a keypad key and leaves the controls alone
		send_frame(SC_UP, 1'b0);
		check_controls_settled();

		// ####################
		// joysticks and rotation
		// ####################
		for (int rot = 0; rot < 2; rot++) begin
			for (int n = 0; n < 20; n++) begin
				@(posedge clock_48);
				rotate     <= (rot == 1);
				joystick_0 <= control_word_t'($random(seed));
				joystick_1 <= control_word_t'($random(seed));
				repeat (2) @(posedge clock_48);
				@(negedge clock_48);
				compare_controls(actual_controls,
					expected_controls(kb_model, joystick_0, joystick_1, rotate));
			end
		end
		@(posedge clock_48);
		joystick_0 <= '0;
		joystick_1 <= '0;
		rotate     <= 1'b1;

		// ####################
		// bad parity, then a good frame
		// ####################
		pulses_before = frame_error_pulses;
		send_frame(SC_F1, 1'b1);
		waited = 0;
		while (frame_error_pulses == pulses_before && waited < SETTLE_LIMIT) begin
			@(negedge clock_48);
			waited++;
		end
		if (frame_error_pulses == pulses_before) begin
			timeout_errors++;
			$display("frame_error did not pulse for a frame with bad parity");
		end
		check_controls_settled();
		key_event(SC_F1, KB_START1, 1'b0, 1'b0);
		key_event(SC_F1, KB_START1, 1'b0, 1'b1);

		// ####################
		// DAC density
		// ####################
		for (int s = 0; s < 6; s++) begin
			if (s == 0) begin
				sample = '0;
			end else if (s == 1) begin
				sample = '1;
			end else begin
				sample = audio_sample_t'($random(seed));
			end
			@(posedge clock_48);
			audio_in <= sample;
			repeat (16) @(posedge clock_48);
			ones = 0;
			repeat (8192) begin
				@(negedge clock_48);
				if (audio_out) begin
					ones++;
				end
			end
			compare_density(sample, ones);
		end

		// ####################
		// video output
		// ####################
		// the second branch checks each cycle's inputs one clock later
		fork
			begin
				for (int n = 0; n < VIDEO_CYCLES; n++) begin
					@(posedge clock_48);
					rnd = $random(seed);
					video_r <= rnd[2:0];
					video_g <= rnd[5:3];
					video_b <= rnd[7:6];
					hblank  <= (rnd[10:8] == 3'd0);
					vblank  <= (rnd[13:11] == 3'd0);
					hs      <= rnd[14];
					vs      <= rnd[15];
				end
			end
			begin
				@(posedge clock_48);
				@(negedge clock_48);
				capture_video_expectation();
				repeat (VIDEO_CYCLES) begin
					@(negedge clock_48);
					compare_vga("vga_r", vga_r, exp_r);
					compare_vga("vga_g", vga_g, exp_g);
					compare_vga("vga_b", vga_b, exp_b);
					compare_bit("vga_hs", vga_hs, exp_hs);
					compare_bit("vga_vs", vga_vs, exp_vs);
					capture_video_expectation();
				end
			end
		join

		// only the one corrupted frame may have raised frame_error
		if (frame_error_pulses != 1) begin
			mismatch_errors++;
			$display("Mismatch frame_error pulse count: got %h expected %h", frame_error_pulses, 1);
		end
		$display("errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
		if (mismatch_errors + timeout_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- design/arcade_io_top.sv
`timescale 1ns/100ps

module arcade_io_top (
	input  logic                      clock_48,
	input  logic                      arst_n,
	input  logic                      ps2_kbd_clk,
	input  logic                      ps2_kbd_data,
	input  arcade_pkg::control_word_t joystick_0,
	input  arcade_pkg::control_word_t joystick_1,
	input  logic                      rotate,
	input  arcade_pkg::audio_sample_t audio_in,
	input  arcade_pkg::game_color_t   video_r,
	input  arcade_pkg::game_color_t   video_g,
	input  logic [1:0]                video_b,
	input  logic                      hblank,
	input  logic                      vblank,
	input  logic                      hs,
	input  logic                      vs,
	output logic                      up,
	output logic                      down,
	output logic                      left,
	output logic                      right,
	output logic                      fire,
	output logic                      start1,
	output logic                      start2,
	output logic                      coin,
	output logic                      audio_out,
	output arcade_pkg::vga_level_t    vga_r,
	output arcade_pkg::vga_level_t    vga_g,
	output arcade_pkg::vga_level_t    vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs,
	output logic                      frame_error
);
	import arcade_pkg::*;

	scan_code_t    code;
	logic          code_valid;
	control_word_t kbjoy;

	// ####################
	// keyboard path
	// ####################
	ps2_receiver ps2_receiver (
		.clock_48     (clock_48),
		.arst_n       (arst_n),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.code         (code),
		.code_valid   (code_valid),
		.frame_error  (frame_error)
	);

	key_decoder key_decoder (
		.clock_48   (clock_48),
		.arst_n     (arst_n),
		.code       (code),
		.code_valid (code_valid),
		.kbjoy      (kbjoy)
	);

	control_mapper control_mapper (
		.clock_48   (clock_48),
		.arst_n     (arst_n),
		.kbjoy      (kbjoy),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.up         (up),
		.down       (down),
		.left       (left),
		.right      (right),
		.fire       (fire),
		.start1     (start1),
		.start2     (start2),
		.coin       (coin)
	);

	// ####################
	// audio and video outputs
	// ####################
	sigma_delta_dac sigma_delta_dac (
		.clock_48  (clock_48),
		.arst_n    (arst_n),
		.audio_in  (audio_in),
		.audio_out (audio_out)
	);

	video_output video_output (
		.clock_48 (clock_48),
		.arst_n   (arst_n),
		.video_r  (video_r),
		.video_g  (video_g),
		.video_b  (video_b),
		.hblank   (hblank),
		.vblank   (vblank),
		.hs       (hs),
		.vs       (vs),
		.vga_r    (vga_r),
		.vga_g    (vga_g),
		.vga_b    (vga_b),
		.vga_hs   (vga_hs),
		.vga_vs   (vga_vs)
	);

endmodule

//--- design/video_output.sv
`timescale 1ns/100ps

module video_output (
	input  logic                    clock_48,
	input  logic                    arst_n,
	input  arcade_pkg::game_color_t video_r,
	input  arcade_pkg::game_color_t video_g,
	input  logic [1:0]              video_b,
	input  logic                    hblank,
	input  logic                    vblank,
	input  logic                    hs,
	input  logic                    vs,
	output arcade_pkg::vga_level_t  vga_r,
	output arcade_pkg::vga_level_t  vga_g,
	output arcade_pkg::vga_level_t  vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs
);
	import arcade_pkg::*;

	game_color_t blue_wide;
	logic        blank;

	// blue is two bits on the game side, the low bit fills the third
	assign blue_wide = {video_b, video_b[0]};
	assign blank     = hblank | vblank;

	// repeating each channel keeps full scale at full scale on the 6-bit DAC
	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r  <= blank ? '0 : {video_r, video_r};
			vga_g  <= blank ? '0 : {video_g, video_g};
			vga_b  <= blank ? '0 : {blue_wide, blue_wide};
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

endmodule

//--- design/sigma_delta_dac.sv
`timescale 1ns/100ps

module sigma_delta_dac (
	input  logic                      clock_48,
	input  logic                      arst_n,
	input  arcade_pkg::audio_sample_t audio_in,
	output logic                      audio_out
);
	import arcade_pkg::*;

	logic [DAC_ACC_W-1:0] acc;
	logic [DAC_ACC_W-1:0] acc_next;

	// ####################
	// first-order modulator
	// ####################
	// the low bits carry the residue forward, the top bit is this cycle's carry
	assign acc_next = {1'b0, acc[AUDIO_W-1:0]} + {1'b0, audio_in};

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

	// one carry per 2^13 of accumulated sample, so the ones density is sample/8192
	assign audio_out = acc[DAC_ACC_W-1];

endmodule

//--- design/control_mapper.sv
`timescale 1ns/100ps

module control_mapper (
	input  logic                      clock_48,
	input  logic                      arst_n,
	input  arcade_pkg::control_word_t kbjoy,
	input  arcade_pkg::control_word_t joystick_0,
	input  arcade_pkg::control_word_t joystick_1,
	input  logic                      rotate,
	output logic                      up,
	output logic                      down,
	output logic                      left,
	output logic                      right,
	output logic                      fire,
	output logic                      start1,
	output logic                      start2,
	output logic                      coin
);
	import arcade_pkg::*;

	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic src_fire;

	// any of the three sources can hold a direction
	assign src_up    = kbjoy[KB_UP] | joystick_0[JOY_UP] | joystick_1[JOY_UP];
	assign src_down  = kbjoy[KB_DOWN] | joystick_0[JOY_DOWN] | joystick_1[JOY_DOWN];
	assign src_left  = kbjoy[KB_LEFT] | joystick_0[JOY_LEFT] | joystick_1[JOY_LEFT];
	assign src_right = kbjoy[KB_RIGHT] | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];
	assign src_fire  = kbjoy[KB_FIRE] | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE];

	// with rotate low the cabinet is turned a quarter, so the stick is remapped
	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			up     <= 1'b0;
			down   <= 1'b0;
			left   <= 1'b0;
			right  <= 1'b0;
			fire   <= 1'b0;
			start1 <= 1'b0;
			start2 <= 1'b0;
			coin   <= 1'b0;
		end else begin
			up     <= rotate ? src_up : src_left;
			down   <= rotate ? src_down : src_right;
			left   <= rotate ? src_left : src_down;
			right  <= rotate ? src_right : src_up;
			fire   <= src_fire;
			start1 <= kbjoy[KB_START1];
			start2 <= kbjoy[KB_START2];
			coin   <= kbjoy[KB_COIN];
		end
	end

endmodule

//--- design/key_decoder.sv
`timescale 1ns/100ps

module key_decoder (
	input  logic                      clock_48,
	input  logic                      arst_n,
	input  arcade_pkg::scan_code_t    code,
	input  logic                      code_valid,
	output arcade_pkg::control_word_t kbjoy
);
	import arcade_pkg::*;

	logic                  release_pending;
	logic                  extended_pending;
	logic                  key_hit;
	logic [CTRL_IDX_W-1:0] key_idx;

	// ####################
	// scan code to key bit
	// ####################
	// arrow codes share values with the keypad, so they only count after E0
	always_comb begin
		key_hit = 1'b1;
		key_idx = '0;
		case (code)
			SC_SPACE: key_idx = CTRL_IDX_W'(KB_FIRE);
			SC_F1:    key_idx = CTRL_IDX_W'(KB_START1);
			SC_F2:    key_idx = CTRL_IDX_W'(KB_START2);
			SC_F3:    key_idx = CTRL_IDX_W'(KB_COIN);
			SC_UP: begin
				key_idx = CTRL_IDX_W'(KB_UP);
				key_hit = extended_pending;
			end
			SC_DOWN: begin
				key_idx = CTRL_IDX_W'(KB_DOWN);
				key_hit = extended_pending;
			end
			SC_LEFT: begin
				key_idx = CTRL_IDX_W'(KB_LEFT);
				key_hit = extended_pending;
			end
			SC_RIGHT: begin
				key_idx = CTRL_IDX_W'(KB_RIGHT);
				key_hit = extended_pending;
			end
			default: begin
				key_hit = 1'b0;
			end
		endcase
	end

	// ####################
	// prefix tracking and key state
	// ####################
	// a break of an arrow arrives as E0 F0 xx, so F0 leaves the extended flag alone
	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			release_pending  <= 1'b0;
			extended_pending <= 1'b0;
			kbjoy            <= '0;
		end else if (code_valid) begin
			if (code == SC_BREAK) begin
				release_pending <= 1'b1;
			end else if (code == SC_EXTENDED) begin
				extended_pending <= 1'b1;
			end else begin
				if (key_hit) begin
					kbjoy[key_idx] <= ~release_pending;
				end
				release_pending  <= 1'b0;
				extended_pending <= 1'b0;
			end
		end
	end

endmodule

//--- design/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver (
	input  logic                   clock_48,
	input  logic                   arst_n,
	input  logic                   ps2_kbd_clk,
	input  logic                   ps2_kbd_data,
	output arcade_pkg::scan_code_t code,
	output logic                   code_valid,
	output logic                   frame_error
);
	import arcade_pkg::*;

	logic [1:0]               pins;
	logic [1:0]               sync_a;
	logic [1:0]               sync_b;
	logic [1:0]               filt;
	logic [PS2_FILTER_W-1:0]  stable_cnt [2];
	logic                     clk_prev;
	logic                     fall;
	logic [PS2_BIT_CNT_W-1:0] bit_cnt;
	logic                     last_bit;
	logic [9:0]               shift_q;
	logic [PS2_IDLE_W-1:0]    idle_cnt;
	logic                     frame_ok;

	assign pins = {ps2_kbd_data, ps2_kbd_clk};

	// ####################
	// line conditioning
	// ####################
	// both lines idle high, so the synchroniser and filter come out of reset at 1
	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			sync_a <= '1;
			sync_b <= '1;
		end else begin
			sync_a <= pins;
			sync_b <= sync_a;
		end
	end

	// a line must disagree with its filtered level for the whole window to flip it
	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2; i++) begin
				filt[i]       <= 1'b1;
				stable_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (sync_b[i] == filt[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == PS2_FILTER_W'(PS2_FILTER_CYCLES - 1)) begin
					filt[i]       <= sync_b[i];
					stable_cnt[i] <= '0;
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	// ####################
	// frame assembly
	// ####################
	assign fall     = clk_prev & ~filt[PS2_CLK_LINE];
	assign last_bit = (bit_cnt == PS2_BIT_CNT_W'(PS2_FRAME_BITS - 1));

	// shift_q holds start in bit 0 and parity in bit 9 when the stop bit arrives
	assign frame_ok = ~shift_q[0] & (^shift_q[9:1]) & filt[PS2_DATA_LINE];

	always_ff @(posedge clock_48 or negedge arst_n) begin
		if (!arst_n) begin
			clk_prev    <= 1'b1;
			bit_cnt     <= '0;
			idle_cnt    <= '0;
			code_valid  <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			clk_prev    <= filt[PS2_CLK_LINE];
			code_valid  <= 1'b0;
			frame_error <= 1'b0;
			if (fall) begin
				idle_cnt <= '0;
				if (last_bit) begin
					bit_cnt     <= '0;
					code_valid  <= frame_ok;
					frame_error <= ~frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (bit_cnt != '0) begin
				// a keyboard that stops mid-frame leaves the counter parked
				if (idle_cnt == PS2_IDLE_W'(PS2_IDLE_TIMEOUT - 1)) begin
					bit_cnt     <= '0;
					idle_cnt    <= '0;
					frame_error <= 1'b1;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock_48) begin
		if (fall) begin
			shift_q <= {filt[PS2_DATA_LINE], shift_q[9:1]};
		end
		if (fall && last_bit) begin
			code <= shift_q[8:1];
		end
	end

endmodule

//--- design/arcade_pkg.sv
package arcade_pkg;

	// ####################
	// widths and payload types
	// ####################
	localparam int CTRL_W     = 8;
	localparam int CTRL_IDX_W = $clog2(CTRL_W);
	localparam int AUDIO_W    = 13;
	localparam int DAC_ACC_W  = AUDIO_W + 1;
	localparam int COLOR_W    = 3;
	localparam int BLUE_W     = 2;
	localparam int VGA_W      = 6;

	typedef logic [7:0]         scan_code_t;
	typedef logic [CTRL_W-1:0]  control_word_t;
	typedef logic [AUDIO_W-1:0] audio_sample_t;
	typedef logic [COLOR_W-1:0] game_color_t;
	typedef logic [VGA_W-1:0]   vga_level_t;

	// keyboard word bit positions
	localparam int KB_FIRE   = 0;
	localparam int KB_START1 = 1;
	localparam int KB_START2 = 2;
	localparam int KB_COIN   = 3;
	localparam int KB_UP     = 4;
	localparam int KB_DOWN   = 5;
	localparam int KB_LEFT   = 6;
	localparam int KB_RIGHT  = 7;

	// joystick word bit positions, as the configuration link packs them
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// ####################
	// PS/2 scan codes
	// ####################
	localparam scan_code_t SC_BREAK    = 8'hF0;
	localparam scan_code_t SC_EXTENDED = 8'hE0;
	localparam scan_code_t SC_SPACE    = 8'h29;
	localparam scan_code_t SC_F1       = 8'h05;
	localparam scan_code_t SC_F2       = 8'h06;
	localparam scan_code_t SC_F3       = 8'h04;
	localparam scan_code_t SC_UP       = 8'h75;
	localparam scan_code_t SC_DOWN     = 8'h72;
	localparam scan_code_t SC_LEFT     = 8'h6B;
	localparam scan_code_t SC_RIGHT    = 8'h74;

	// PS/2 line indices and frame timing
	localparam int PS2_CLK_LINE      = 0;
	localparam int PS2_DATA_LINE     = 1;
	localparam int PS2_FRAME_BITS    = 11;
	localparam int PS2_BIT_CNT_W     = 4;
	localparam int PS2_FILTER_CYCLES = 8;
	localparam int PS2_FILTER_W      = $clog2(PS2_FILTER_CYCLES);
	localparam int PS2_IDLE_TIMEOUT  = 4096;
	localparam int PS2_IDLE_W        = $clog2(PS2_IDLE_TIMEOUT);

endpackage
